// File: hdl/spi_pkg.sv
`default_nettype none

package spi_pkg;

  localparam int cmd_w        = 12;
  localparam int read_w       = 8;
  localparam int addr_w       = cmd_w - 1 - read_w;
  localparam int rd_addr_bits = 1 + addr_w;   // Flag plus address
  localparam int half_div     = 4;            // clk cycles per sclk half period
  localparam int read_gap     = 16;           // cs_n high time between read frames

  localparam int div_w = $clog2(half_div);
  localparam int cnt_w = $clog2(read_gap) + 1;

  typedef logic [div_w-1:0] div_t;
  typedef logic [cnt_w-1:0] cnt_t;

  typedef struct packed {
    logic              is_wr;
    logic [addr_w-1:0] addr;
    logic [read_w-1:0] data;
  } wr_view_t;

  typedef struct packed {
    logic              is_wr;
    logic [addr_w-1:0] addr;
    logic [read_w-1:0] unused;   // Not sent on reads
  } rd_view_t;

  typedef union packed {
    wr_view_t wr;
    rd_view_t rd;
  } spi_cmd_u;

  typedef enum logic [1:0] {
    ph_write,
    ph_rd_addr,
    ph_rd_data
  } phase_e;

  typedef struct packed {
    logic   load;
    logic   frame_en;
    phase_e phase;
    logic   gap_en;
    logic   done;
  } seq_ctrl_t;

  typedef struct packed {
    logic rise;
    logic fall;
    logic frame_last;
    logic gap_over;
  } tmr_stat_t;

endpackage

`default_nettype wire

// File: hdl/spi_seq_fsm.sv
`default_nettype none

module spi_seq_fsm (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire                     cmd_vld,
  input  wire spi_pkg::tmr_stat_t tmr,
  input  wire                     is_wr,
  output logic                    cmd_rdy,
  output logic                    cs_n,
  output logic                    read_vld,
  output spi_pkg::seq_ctrl_t      ctrl
);

  typedef enum logic [2:0] {
    st_idle,
    st_wr_frame,
    st_rd_addr_frame,
    st_rd_gap,
    st_rd_data_frame,
    st_finish
  } state_e;

  state_e state;
  state_e state_nxt;
  logic   take_q;        // Command stored, branch next
  logic   frame_nxt;

  // Finish already accepts the next command
  assign cmd_rdy  = ((state == st_idle) && !take_q) || (state == st_finish);
  assign read_vld = (state == st_finish) && !is_wr;

  assign frame_nxt = state_nxt inside {st_wr_frame, st_rd_addr_frame, st_rd_data_frame};

  always_comb
  begin
    state_nxt = state;
    case (state)
      st_idle:
        if (take_q)
          state_nxt = is_wr ? st_wr_frame : st_rd_addr_frame;
      st_wr_frame:
        if (tmr.frame_last)
          state_nxt = st_finish;
      st_rd_addr_frame:
        if (tmr.frame_last)
          state_nxt = st_rd_gap;
      st_rd_gap:
        if (tmr.gap_over)
          state_nxt = st_rd_data_frame;
      st_rd_data_frame:
        if (tmr.frame_last)
          state_nxt = st_finish;
      default:
        state_nxt = st_idle;
    endcase
  end

  always_comb
  begin
    ctrl.load     = cmd_rdy && cmd_vld;
    ctrl.frame_en = state inside {st_wr_frame, st_rd_addr_frame, st_rd_data_frame};
    ctrl.gap_en   = (state == st_rd_gap);
    ctrl.done     = (state == st_finish);
    case (state)
      st_idle:
        ctrl.phase = is_wr ? spi_pkg::ph_write : spi_pkg::ph_rd_addr;  // Timer preload
      st_rd_addr_frame:
        ctrl.phase = spi_pkg::ph_rd_addr;
      st_rd_gap,
      st_rd_data_frame:
        ctrl.phase = spi_pkg::ph_rd_data;
      default:
        ctrl.phase = spi_pkg::ph_write;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= st_idle;
      take_q <= 1'b0;
      cs_n   <= 1'b1;
    end
    else
    begin
      state  <= state_nxt;
      take_q <= ctrl.load;
      cs_n   <= !frame_nxt;   // Low for exactly the frame states
    end
  end

endmodule

`default_nettype wire

// File: hdl/spi_bit_timer.sv
`default_nettype none

module spi_bit_timer (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire spi_pkg::seq_ctrl_t ctrl,
  output logic                    sclk,
  output spi_pkg::tmr_stat_t      tmr
);

  spi_pkg::div_t div_cnt;
  spi_pkg::cnt_t cnt;       // Bits left in frame, or gap cycles elapsed
  logic          tick;

  function automatic spi_pkg::cnt_t frame_len(spi_pkg::phase_e ph);
    case (ph)
      spi_pkg::ph_write:   frame_len = spi_pkg::cnt_t'(spi_pkg::cmd_w);
      spi_pkg::ph_rd_addr: frame_len = spi_pkg::cnt_t'(spi_pkg::rd_addr_bits);
      default:             frame_len = spi_pkg::cnt_t'(spi_pkg::read_w);
    endcase
  endfunction

  assign tick = ctrl.frame_en && (div_cnt == spi_pkg::div_t'(spi_pkg::half_div - 1));

  // First half period of a frame is the setup before the first rise
  always_comb
  begin
    tmr.rise       = tick && !sclk && (cnt != '0);
    tmr.fall       = tick && sclk;
    tmr.frame_last = tick && !sclk && (cnt == '0);
    tmr.gap_over   = ctrl.gap_en && (cnt == spi_pkg::cnt_t'(spi_pkg::read_gap - 1));
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      div_cnt <= '0;
    else if (!ctrl.frame_en || tick)
      div_cnt <= '0;
    else
      div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      sclk <= 1'b0;
    else if (tmr.rise)
      sclk <= 1'b1;
    else if (tmr.fall || !ctrl.frame_en)
      sclk <= 1'b0;
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      cnt <= '0;
    else if (ctrl.frame_en)
    begin
      if (tmr.fall)
        cnt <= cnt - 1'b1;
    end
    else if (ctrl.gap_en && !tmr.gap_over)
      cnt <= cnt + 1'b1;       // Address frame leaves it at zero
    else
      cnt <= frame_len(ctrl.phase);   // Preload for the coming frame
  end

endmodule

`default_nettype wire

// File: hdl/spi_shifter.sv
`default_nettype none

module spi_shifter (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire spi_pkg::seq_ctrl_t          ctrl,
  input  wire spi_pkg::tmr_stat_t          tmr,
  input  wire spi_pkg::spi_cmd_u           cmd_in,
  input  wire                              miso,
  output spi_pkg::spi_cmd_u                cmd,
  output logic                             mosi,
  output logic [spi_pkg::read_w-1:0]       read_data
);

  logic [spi_pkg::cmd_w-1:0]  tx_sreg;
  logic [spi_pkg::read_w-1:0] rx_sreg;
  logic                       tx_phase;
  logic                       rx_phase;

  assign tx_phase = ctrl.frame_en && (ctrl.phase != spi_pkg::ph_rd_data);
  assign rx_phase = ctrl.frame_en && (ctrl.phase == spi_pkg::ph_rd_data);

  assign mosi = tx_phase && tx_sreg[spi_pkg::cmd_w-1];   // MSB first and low outside frames

  always_ff @(posedge clk)
  begin
    if (ctrl.load)
    begin
      cmd <= cmd_in;
      if (cmd_in.wr.is_wr)
        tx_sreg <= cmd_in;
      else
        tx_sreg <= {cmd_in.rd.is_wr, cmd_in.rd.addr, {spi_pkg::read_w{1'b0}}};
    end
    else if (tx_phase && tmr.fall)
      tx_sreg <= {tx_sreg[spi_pkg::cmd_w-2:0], 1'b0};
  end

  // Sampled on the sclk rising edge
  always_ff @(posedge clk)
  begin
    if (ctrl.done)
      rx_sreg <= '0;
    else if (rx_phase && tmr.rise)
      rx_sreg <= {rx_sreg[spi_pkg::read_w-2:0], miso};
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_data <= '0;
    else if (rx_phase && tmr.frame_last)
      read_data <= rx_sreg;   // Ready for the read_vld cycle
  end

endmodule

`default_nettype wire

// File: hdl/spi_cmd_master.sv
`default_nettype none

module spi_cmd_master (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire spi_pkg::spi_cmd_u           cmd_in,
  input  wire                              cmd_vld,
  input  wire                              miso,
  output wire                              cmd_rdy,
  output wire                              sclk,
  output wire                              cs_n,
  output wire                              mosi,
  output wire                              read_vld,
  output wire [spi_pkg::read_w-1:0]        read_data
);

  wire spi_pkg::seq_ctrl_t ctrl;
  wire spi_pkg::tmr_stat_t tmr;
  wire spi_pkg::spi_cmd_u  cmd;    // Stored command

  spi_seq_fsm spi_seq_fsm_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .tmr      (tmr),
    .is_wr    (cmd.wr.is_wr),
    .cmd_rdy  (cmd_rdy),
    .cs_n     (cs_n),
    .read_vld (read_vld),
    .ctrl     (ctrl)
  );

  spi_bit_timer spi_bit_timer_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .ctrl  (ctrl),
    .sclk  (sclk),
    .tmr   (tmr)
  );

  spi_shifter spi_shifter_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .ctrl      (ctrl),
    .tmr       (tmr),
    .cmd_in    (cmd_in),
    .miso      (miso),
    .cmd       (cmd),
    .mosi      (mosi),
    .read_data (read_data)
  );

endmodule

`default_nettype wire

// File: verification/spi_slave_model.sv
`default_nettype none

module spi_slave_model (
  input  wire                       sclk,
  input  wire                       cs_n,
  input  wire                       mosi,
  output logic                      miso,
  output logic [spi_pkg::cmd_w-1:0] frame_word    // Last write frame seen
);

  timeunit 1ns;
  timeprecision 100ps;

  logic [7:0]  regs [8];
  logic [11:0] rx_word    = '0;
  logic [7:0]  tx_byte    = '0;
  logic [2:0]  rd_addr    = '0;
  int          nbits      = 0;
  logic        rd_pending = 1'b0;
  logic        data_frame = 1'b0;

  initial
  begin
    miso       = 1'b0;
    frame_word = '0;
    for (int i = 0; i < 8; i++)
      regs[i] = 8'hA0 + 8'(i);
  end

  always @(negedge cs_n)
  begin
    nbits   = 0;
    rx_word = '0;
    if (rd_pending)
    begin
      rd_pending = 1'b0;
      data_frame = 1'b1;
      tx_byte    = regs[rd_addr];
      miso       = tx_byte[7];   // First bit before the first rise
    end
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      rx_word = {rx_word[10:0], mosi};
      nbits   = nbits + 1;
    end
  end

  always @(negedge sclk)
  begin
    if (!cs_n && data_frame)
    begin
      tx_byte = {tx_byte[6:0], 1'b0};
      miso    = tx_byte[7];
    end
  end

  // Frame decode when chip select closes
  always @(posedge cs_n)
  begin
    if (data_frame)
      data_frame = 1'b0;
    else if (nbits == 12 && rx_word[11])
    begin
      regs[rx_word[10:8]] = rx_word[7:0];
      frame_word          = rx_word;
    end
    else if (nbits == 4 && !rx_word[3])
    begin
      rd_addr    = rx_word[2:0];
      rd_pending = 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verification/spi_cmd_master_asserts.sv
`default_nettype none

module spi_cmd_master_asserts (
  input wire clk,
  input wire rst_n,
  input wire sclk,
  input wire cs_n,
  input wire cmd_rdy,
  input wire read_vld
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;   // Read by the testbench at the end

  sclk_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(sclk) |-> !cs_n)
  else
  begin
    $error("sclk toggled while cs_n was high");
    fail_count++;
  end

  read_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
  else
  begin
    $error("read_vld stayed high for more than one cycle");
    fail_count++;
  end

  busy_in_frame: assert property (@(posedge clk) disable iff (!rst_n)
    !cs_n |-> !cmd_rdy)
  else
  begin
    $error("cmd_rdy high while cs_n low");
    fail_count++;
  end

  // Only the address frame ends with cmd_rdy still low
  read_gap_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs_n) && !cmd_rdy |-> cs_n [*spi_pkg::read_gap])
  else
  begin
    $error("cs_n gap between read frames too short");
    fail_count++;
  end

endmodule

bind spi_cmd_master spi_cmd_master_asserts asserts_inst (
  .clk      (clk),
  .rst_n    (rst_n),
  .sclk     (sclk),
  .cs_n     (cs_n),
  .cmd_rdy  (cmd_rdy),
  .read_vld (read_vld)
);

`default_nettype wire

// File: verification/tb_spi_cmd_master.sv
`default_nettype none

module tb_spi_cmd_master;

  timeunit 1ns;
  timeprecision 100ps;

  localparam time clk_period = 40ns;
  localparam int  n_cmds     = 46;
  localparam time limit      = n_cmds * 40 * spi_pkg::half_div * clk_period + 20 * clk_period;

  logic                     clk = 1'b0;
  logic                     rst_n;
  spi_pkg::spi_cmd_u        cmd_in;
  logic                     cmd_vld;
  wire                      miso;
  wire                      cmd_rdy;
  wire                      sclk;
  wire                      cs_n;
  wire                      mosi;
  wire                      read_vld;
  wire [spi_pkg::read_w-1:0] read_data;
  wire [spi_pkg::cmd_w-1:0]  frame_word;

  logic [7:0] ref_regs [8];
  logic [7:0] exp_q [$];
  int         errors   = 0;
  int         checks   = 0;
  int         tests    = 0;
  int         test_err = 0;
  int         cs_falls = 0;

  spi_cmd_master spi_cmd_master_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .miso      (miso),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .read_vld  (read_vld),
    .read_data (read_data)
  );

  spi_slave_model slave_inst (
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .miso       (miso),
    .frame_word (frame_word)
  );

  initial
  begin
    forever #(clk_period / 2) clk = ~clk;
  end

  // Register image of the peripheral updated in command order
  function automatic logic [7:0] expected_read(input spi_pkg::spi_cmd_u c);
    if (c.wr.is_wr)
    begin
      ref_regs[c.wr.addr] = c.wr.data;
      return 8'h00;
    end
    return ref_regs[c.rd.addr];
  endfunction

  function automatic spi_pkg::spi_cmd_u make_cmd(input logic wr, input logic [2:0] addr,
                                                 input logic [7:0] data);
    spi_pkg::spi_cmd_u c;
    c.wr.is_wr = wr;
    c.wr.addr  = addr;
    c.wr.data  = data;
    return c;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("ERROR %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic next_cycle;
    @(posedge clk);
    #2;
  endtask

  // With hold, cmd_vld stays high and cmd_in keeps changing while busy
  task automatic issue(input spi_pkg::spi_cmd_u c, input bit hold);
    logic [7:0] exp;
    cmd_in  = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy)
      next_cycle();
    next_cycle();
    exp = expected_read(c);
    if (!c.wr.is_wr)
      exp_q.push_back(exp);
    while (hold && !cmd_rdy)
    begin
      cmd_in = make_cmd(1'($urandom), 3'($urandom), 8'($urandom));
      next_cycle();
    end
    cmd_vld = 1'b0;
    while (!cmd_rdy || exp_q.size() != 0)
      next_cycle();
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s %s", tests, name, (errors == test_err) ? "ok" : "failed");
    test_err = errors;
  endtask

  always @(negedge cs_n)
  begin
    if (rst_n)
      cs_falls++;
  end

  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      if (exp_q.size() == 0)
      begin
        $display("read_vld pulsed at %0t ns with no read pending", $time);
        errors++;
      end
      else
        compare("read_data", read_data, exp_q.pop_front());
    end
  end

  initial
  begin
    spi_pkg::spi_cmd_u c;
    int                falls0;
    void'($urandom(32'h1f40_267a));
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    for (int i = 0; i < 8; i++)
      ref_regs[i] = 8'hA0 + 8'(i);
    repeat (8) @(posedge clk);
    #2;
    rst_n = 1'b1;
    compare("cmd_rdy", cmd_rdy, 1'b1);
    compare("cs_n", cs_n, 1'b1);
    compare("sclk", sclk, 1'b0);
    compare("mosi", mosi, 1'b0);
    compare("read_vld", read_vld, 1'b0);
    end_test("reset");

    c = make_cmd(1'b1, 3'd5, 8'h3c);
    issue(c, 1'b0);
    compare("write frame", frame_word, c);
    next_cycle();
    compare("cmd_rdy after write", cmd_rdy, 1'b1);
    end_test("write frame");

    issue(make_cmd(1'b1, 3'd2, 8'h5a), 1'b0);
    issue(make_cmd(1'b0, 3'd2, 8'h00), 1'b0);
    compare("read back reg 2", read_data, 8'h5a);
    end_test("write read");

    issue(make_cmd(1'b0, 3'd7, 8'h00), 1'b0);
    compare("unwritten reg 7", read_data, 8'ha7);
    end_test("reset value");

    falls0 = cs_falls;
    issue(make_cmd(1'b1, 3'd3, 8'hc3), 1'b1);
    issue(make_cmd(1'b0, 3'd3, 8'h00), 1'b1);
    compare("cs_n falling edges", cs_falls - falls0, 3);
    end_test("busy hold");

    repeat (40)
    begin
      issue(make_cmd(1'($urandom), 3'($urandom), 8'($urandom)), 1'b0);
      repeat ($urandom_range(5, 0))
        next_cycle();
    end
    end_test("random");

    errors = errors + int'(spi_cmd_master_inst.asserts_inst.fail_count);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    #(limit);
    $display("Watchdog expired at %0t ns, a command never completed", $time);
    $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: spi_cmd_master.f
hdl/spi_pkg.sv
hdl/spi_seq_fsm.sv
hdl/spi_bit_timer.sv
hdl/spi_shifter.sv
hdl/spi_cmd_master.sv
verification/spi_slave_model.sv
verification/spi_cmd_master_asserts.sv
verification/tb_spi_cmd_master.sv

// File: Bender.yml
package:
  name: spi_cmd_master

sources:
  - files:
      - hdl/spi_pkg.sv
      - hdl/spi_seq_fsm.sv
      - hdl/spi_bit_timer.sv
      - hdl/spi_shifter.sv
      - hdl/spi_cmd_master.sv
  - target: test
    files:
      - verification/spi_slave_model.sv
      - verification/spi_cmd_master_asserts.sv
      - verification/tb_spi_cmd_master.sv
